//--- hw/la_pkg.sv
package la_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // 3R opcodes sit in inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 group, inst[31:22]
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_ld_w   = 10'h0a2;
    localparam logic [9:0] op_st_w   = 10'h0a6;

    localparam logic [6:0] op_lu12i_w = 7'h0a;   // 1RI20, inst[31:25]

    // branch opcodes in inst[31:26]
    localparam logic [5:0] op_beq = 6'h16;
    localparam logic [5:0] op_bne = 6'h17;
    localparam logic [5:0] op_b   = 6'h14;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_passb   // lu12i.w
    } alu_op_e;

    typedef enum logic {
        wb_alu,
        wb_load
    } wb_sel_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_b
    } br_kind_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [31:0]     inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rk;       // rk, or rd for st.w and beq/bne
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rj_val;
        logic [xlen-1:0]       rk_val;
        logic [xlen-1:0]       imm;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        wb_sel_e               wb_sel;
        br_kind_e              br;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  reg_write;
        logic                  mem_read;
        wb_sel_e               wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic [xlen-1:0]       wdata;
    } mem_wb_t;

endpackage

//--- hw/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     hold,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // an all-zero payload is a bubble
    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            q <= '0;
        end
        else if (!hold)
        begin
            q <= d;
        end
    end

endmodule

//--- hw/fetch_stage.sv
module fetch_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    branch_taken,
    input  logic [la_pkg::xlen-1:0] branch_target,
    output logic [la_pkg::xlen-1:0] pc,
    output logic                    inst_sram_en,
    output logic [la_pkg::xlen-1:0] inst_sram_addr
);

    logic [la_pkg::xlen-1:0] npc;

    // next pc doubles as the sram address, so the word lines up with pc a cycle later
    always_comb
    begin
        if (rst)
        begin
            npc = la_pkg::reset_pc;   // reset vector is read in the last reset cycle
        end
        else if (branch_taken)
        begin
            npc = branch_target;      // beats a pending stall
        end
        else if (stall)
        begin
            npc = pc;                 // re-read the same word
        end
        else
        begin
            npc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= la_pkg::reset_pc;
        else
            pc <= npc;
    end

    assign inst_sram_en   = 1'b1;  // read every cycle
    assign inst_sram_addr = npc;

endmodule

//--- hw/decode_unit.sv
module decode_unit (
    input  la_pkg::if_id_t                id_in,
    output logic [la_pkg::reg_addr_w-1:0] rj_addr,
    output logic [la_pkg::reg_addr_w-1:0] rk_addr,
    input  logic [la_pkg::xlen-1:0]       rj_data,
    input  logic [la_pkg::xlen-1:0]       rk_data,
    output la_pkg::id_ex_t                id_out
);

    logic [31:0] inst;
    logic        is_3r;
    logic        is_addi;
    logic        is_lu12i;
    logic        is_ld;
    logic        is_st;
    logic        is_beq;
    logic        is_bne;
    logic        is_b;
    logic        dst_write;

    logic [la_pkg::xlen-1:0] imm_si12;
    logic [la_pkg::xlen-1:0] imm_si20;
    logic [la_pkg::xlen-1:0] imm_offs16;
    logic [la_pkg::xlen-1:0] imm_offs26;

    assign inst = id_in.inst;

    assign is_3r    = inst[31:15] inside {la_pkg::op_add_w, la_pkg::op_sub_w, la_pkg::op_slt,
                                          la_pkg::op_sltu, la_pkg::op_and, la_pkg::op_or,
                                          la_pkg::op_xor};
    assign is_addi  = inst[31:22] == la_pkg::op_addi_w;
    assign is_ld    = inst[31:22] == la_pkg::op_ld_w;
    assign is_st    = inst[31:22] == la_pkg::op_st_w;
    assign is_lu12i = inst[31:25] == la_pkg::op_lu12i_w;
    assign is_beq   = inst[31:26] == la_pkg::op_beq;
    assign is_bne   = inst[31:26] == la_pkg::op_bne;
    assign is_b     = inst[31:26] == la_pkg::op_b;

    assign imm_si12   = {{20{inst[21]}}, inst[21:10]};
    assign imm_si20   = {inst[24:5], 12'b0};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};   // offs[25:16] in low bits

    // stores and compares read rd as their second source
    assign rj_addr = inst[9:5];
    assign rk_addr = (is_st || is_beq || is_bne) ? inst[4:0] : inst[14:10];

    always_comb
    begin
        id_out        = '0;    // unknown opcodes stay a no-op
        id_out.pc     = id_in.pc;
        id_out.rj     = rj_addr;
        id_out.rk     = rk_addr;
        id_out.rd     = inst[4:0];
        id_out.rj_val = rj_data;
        id_out.rk_val = rk_data;
        dst_write     = 1'b0;

        if (is_3r)
        begin
            dst_write = 1'b1;
            case (inst[31:15])
                la_pkg::op_sub_w: id_out.alu_op = la_pkg::alu_sub;
                la_pkg::op_slt:   id_out.alu_op = la_pkg::alu_slt;
                la_pkg::op_sltu:  id_out.alu_op = la_pkg::alu_sltu;
                la_pkg::op_and:   id_out.alu_op = la_pkg::alu_and;
                la_pkg::op_or:    id_out.alu_op = la_pkg::alu_or;
                la_pkg::op_xor:   id_out.alu_op = la_pkg::alu_xor;
                default:          id_out.alu_op = la_pkg::alu_add;
            endcase
        end
        else if (is_addi || is_ld || is_st)
        begin
            dst_write        = !is_st;
            id_out.imm       = imm_si12;
            id_out.use_imm   = 1'b1;
            id_out.mem_read  = is_ld;
            id_out.mem_write = is_st;
            id_out.wb_sel    = is_ld ? la_pkg::wb_load : la_pkg::wb_alu;
        end
        else if (is_lu12i)
        begin
            dst_write      = 1'b1;
            id_out.imm     = imm_si20;
            id_out.use_imm = 1'b1;
            id_out.alu_op  = la_pkg::alu_passb;
        end
        else if (is_beq || is_bne)
        begin
            id_out.imm = imm_offs16;
            id_out.br  = is_beq ? la_pkg::br_beq : la_pkg::br_bne;
        end
        else if (is_b)
        begin
            id_out.imm = imm_offs26;
            id_out.br  = la_pkg::br_b;
        end

        // r0 is never written, so it is never forwarded either
        id_out.reg_write = dst_write && (inst[4:0] != '0);
    end

endmodule

//--- hw/reg_file.sv
module reg_file (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [la_pkg::reg_addr_w-1:0] ra1,
    input  logic [la_pkg::reg_addr_w-1:0] ra2,
    output logic [la_pkg::xlen-1:0]       rd1,
    output logic [la_pkg::xlen-1:0]       rd2,
    input  logic                          we,
    input  logic [la_pkg::reg_addr_w-1:0] wa,
    input  logic [la_pkg::xlen-1:0]       wd
);

    logic [la_pkg::xlen-1:0] regs [0:(1 << la_pkg::reg_addr_w)-1];
    logic                    wr_live;

    assign wr_live = we && (wa != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < (1 << la_pkg::reg_addr_w); i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_live)
        begin
            regs[wa] <= wd;
        end
    end

    // write-first, decode sees the value retiring in the same cycle
    assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

//--- hw/execute_stage.sv
module execute_stage (
    input  la_pkg::id_ex_t          ex_in,
    input  la_pkg::ex_mem_t         mem_fwd,
    input  la_pkg::mem_wb_t         wb_fwd,
    output la_pkg::ex_mem_t         ex_out,
    output logic                    branch_taken,
    output logic [la_pkg::xlen-1:0] branch_target,
    output logic                    data_sram_en,
    output logic [3:0]              data_sram_we,
    output logic [la_pkg::xlen-1:0] data_sram_addr,
    output logic [la_pkg::xlen-1:0] data_sram_wdata
);

    logic [la_pkg::xlen-1:0] src_a;
    logic [la_pkg::xlen-1:0] src_b;
    logic [la_pkg::xlen-1:0] op_b;
    logic [la_pkg::xlen-1:0] alu_y;

    // memory stage is younger than writeback, so it is checked first
    function automatic logic [la_pkg::xlen-1:0] pick_src(
        input logic [la_pkg::reg_addr_w-1:0] num,
        input logic [la_pkg::xlen-1:0]       reg_val,
        input la_pkg::ex_mem_t               m,
        input la_pkg::mem_wb_t               w
    );
        if (m.reg_write && m.rd == num)
            return m.result;
        else if (w.reg_write && w.rd == num)
            return w.wdata;
        else
            return reg_val;
    endfunction

    assign src_a = pick_src(ex_in.rj, ex_in.rj_val, mem_fwd, wb_fwd);
    assign src_b = pick_src(ex_in.rk, ex_in.rk_val, mem_fwd, wb_fwd);
    assign op_b  = ex_in.use_imm ? ex_in.imm : src_b;

    always_comb
    begin
        case (ex_in.alu_op)
            la_pkg::alu_add:  alu_y = src_a + op_b;
            la_pkg::alu_sub:  alu_y = src_a - op_b;
            la_pkg::alu_slt:  alu_y = {{(la_pkg::xlen-1){1'b0}}, $signed(src_a) < $signed(op_b)};
            la_pkg::alu_sltu: alu_y = {{(la_pkg::xlen-1){1'b0}}, src_a < op_b};
            la_pkg::alu_and:  alu_y = src_a & op_b;
            la_pkg::alu_or:   alu_y = src_a | op_b;
            la_pkg::alu_xor:  alu_y = src_a ^ op_b;
            default:          alu_y = op_b;   // alu_passb
        endcase
    end

    always_comb
    begin
        case (ex_in.br)
            la_pkg::br_beq: branch_taken = (src_a == src_b);
            la_pkg::br_bne: branch_taken = (src_a != src_b);
            la_pkg::br_b:   branch_taken = 1'b1;
            default:        branch_taken = 1'b0;
        endcase
    end

    assign branch_target = ex_in.pc + ex_in.imm;

    always_comb
    begin
        ex_out.pc        = ex_in.pc;
        ex_out.rd        = ex_in.rd;
        ex_out.result    = alu_y;
        ex_out.reg_write = ex_in.reg_write;
        ex_out.mem_read  = ex_in.mem_read;
        ex_out.wb_sel    = ex_in.wb_sel;
    end

    // word access only, address is rj + si12
    assign data_sram_en    = ex_in.mem_read || ex_in.mem_write;
    assign data_sram_we    = {4{ex_in.mem_write}};
    assign data_sram_addr  = alu_y;
    assign data_sram_wdata = src_b;

endmodule

//--- hw/hazard_unit.sv
module hazard_unit (
    input  logic [la_pkg::reg_addr_w-1:0] id_rj,
    input  logic [la_pkg::reg_addr_w-1:0] id_rk,
    input  logic [la_pkg::reg_addr_w-1:0] ex_rd,
    input  logic                          ex_mem_read,
    input  logic                          branch_taken,
    output logic                          stall,
    output logic                          if_id_flush,
    output logic                          id_ex_flush
);

    logic load_use;

    // load in execute feeding the instruction in decode
    assign load_use = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rj || ex_rd == id_rk);

    // a taken branch squashes the consumer anyway
    assign stall       = load_use && !branch_taken;
    assign if_id_flush = branch_taken;
    assign id_ex_flush = branch_taken || load_use;   // bubble behind the load

endmodule

//--- hw/mem_wb_stage.sv
module mem_wb_stage (
    input  la_pkg::ex_mem_t               mem_in,
    input  logic [la_pkg::xlen-1:0]       data_sram_rdata,
    output la_pkg::mem_wb_t               wb_out,
    input  la_pkg::mem_wb_t               wb_in,
    output logic [la_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output logic [la_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [la_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic use_load;

    // load word returns this cycle for the address sent from execute
    assign use_load = mem_in.mem_read && (mem_in.wb_sel == la_pkg::wb_load);

    always_comb
    begin
        wb_out.pc        = mem_in.pc;
        wb_out.rd        = mem_in.rd;
        wb_out.reg_write = mem_in.reg_write;
        wb_out.wdata     = use_load ? data_sram_rdata : mem_in.result;
    end

    // trace follows the registered writeback payload
    assign debug_wb_pc       = wb_in.pc;
    assign debug_wb_rf_we    = {4{wb_in.reg_write}};
    assign debug_wb_rf_wnum  = wb_in.rd;
    assign debug_wb_rf_wdata = wb_in.wdata;

endmodule

//--- hw/la_core_top.sv
module la_core_top (
    input  logic                          clk,
    input  logic                          rst,
    output logic                          inst_sram_en,
    output logic [la_pkg::xlen-1:0]       inst_sram_addr,
    input  logic [la_pkg::xlen-1:0]       inst_sram_rdata,
    output logic                          data_sram_en,
    output logic [3:0]                    data_sram_we,
    output logic [la_pkg::xlen-1:0]       data_sram_addr,
    output logic [la_pkg::xlen-1:0]       data_sram_wdata,
    input  logic [la_pkg::xlen-1:0]       data_sram_rdata,
    output logic [la_pkg::xlen-1:0]       debug_wb_pc,
    output logic [3:0]                    debug_wb_rf_we,
    output logic [la_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [la_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic [la_pkg::xlen-1:0]       pc;
    logic [la_pkg::reg_addr_w-1:0] rj_addr;
    logic [la_pkg::reg_addr_w-1:0] rk_addr;
    logic [la_pkg::xlen-1:0]       rj_data;
    logic [la_pkg::xlen-1:0]       rk_data;
    logic                          branch_taken;
    logic [la_pkg::xlen-1:0]       branch_target;
    logic                          stall;
    logic                          if_id_flush;
    logic                          id_ex_flush;

    la_pkg::if_id_t  if_id_d,  if_id_q;
    la_pkg::id_ex_t  id_ex_d,  id_ex_q;
    la_pkg::ex_mem_t ex_mem_d, ex_mem_q;
    la_pkg::mem_wb_t mem_wb_d, mem_wb_q;
    la_pkg::ex_mem_t mem_fwd;

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .stall(stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(pc), .inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr)
    );

    assign if_id_d = '{pc: pc, inst: inst_sram_rdata};

    pipe_reg #(.payload_t(la_pkg::if_id_t)) if_id (
        .clk(clk), .rst(rst), .hold(stall), .flush(if_id_flush), .d(if_id_d), .q(if_id_q)
    );

    decode_unit u_decode (
        .id_in(if_id_q), .rj_addr(rj_addr), .rk_addr(rk_addr),
        .rj_data(rj_data), .rk_data(rk_data), .id_out(id_ex_d)
    );

    reg_file u_rf (
        .clk(clk), .rst(rst), .ra1(rj_addr), .ra2(rk_addr), .rd1(rj_data), .rd2(rk_data),
        .we(mem_wb_q.reg_write), .wa(mem_wb_q.rd), .wd(mem_wb_q.wdata)
    );

    hazard_unit u_hazard (
        .id_rj(rj_addr), .id_rk(rk_addr), .ex_rd(id_ex_q.rd), .ex_mem_read(id_ex_q.mem_read),
        .branch_taken(branch_taken), .stall(stall),
        .if_id_flush(if_id_flush), .id_ex_flush(id_ex_flush)
    );

    pipe_reg #(.payload_t(la_pkg::id_ex_t)) id_ex (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(id_ex_flush), .d(id_ex_d), .q(id_ex_q)
    );

    // the memory stage forwards its final write data, so a load is usable after one bubble
    always_comb
    begin
        mem_fwd        = ex_mem_q;
        mem_fwd.result = mem_wb_d.wdata;
    end

    execute_stage u_execute (
        .ex_in(id_ex_q), .mem_fwd(mem_fwd), .wb_fwd(mem_wb_q), .ex_out(ex_mem_d),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata)
    );

    pipe_reg #(.payload_t(la_pkg::ex_mem_t)) ex_mem (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    mem_wb_stage u_mem_wb (
        .mem_in(ex_mem_q), .data_sram_rdata(data_sram_rdata),
        .wb_out(mem_wb_d), .wb_in(mem_wb_q),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    pipe_reg #(.payload_t(la_pkg::mem_wb_t)) mem_wb (
        .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

endmodule

//--- bench/la_core_chk.sv
module la_core_chk (
    input logic                          clk,
    input logic                          rst,
    input logic                          data_sram_en,
    input logic [3:0]                    data_sram_we,
    input logic [la_pkg::xlen-1:0]       data_sram_addr,
    input logic [3:0]                    debug_wb_rf_we,
    input logic [la_pkg::reg_addr_w-1:0] debug_wb_rf_wnum
);

    int fail_count = 0;

    a_we_needs_en: assert property (@(posedge clk) disable iff (rst)
        (data_sram_we != 4'h0) |-> data_sram_en)
    else
    begin
        $error("data_sram_we set while data_sram_en is low");
        fail_count++;
    end

    // word access only
    a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        data_sram_en |-> (data_sram_addr[1:0] == 2'b00))
    else
    begin
        $error("data_sram_addr %h not word aligned", data_sram_addr);
        fail_count++;
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        (debug_wb_rf_we != 4'h0) |-> (debug_wb_rf_wnum != '0))
    else
    begin
        $error("trace reports a write to r0");
        fail_count++;
    end

    // from the second reset edge on, every stage register is already clear
    a_quiet_in_reset: assert property (@(posedge clk)
        (rst ##1 rst) |-> (!data_sram_en && data_sram_we == 4'h0 && debug_wb_rf_we == 4'h0))
    else
    begin
        $error("enable high while rst is asserted");
        fail_count++;
    end

endmodule

bind la_core_top la_core_chk u_chk (
    .clk(clk),
    .rst(rst),
    .data_sram_en(data_sram_en),
    .data_sram_we(data_sram_we),
    .data_sram_addr(data_sram_addr),
    .debug_wb_rf_we(debug_wb_rf_we),
    .debug_wb_rf_wnum(debug_wb_rf_wnum)
);

//--- bench/la_core_tb.sv
module la_core_tb;

    typedef enum int {
        k_add, k_sub, k_slt, k_sltu, k_and, k_or, k_xor,
        k_addi, k_lu12i, k_ld, k_st, k_beq, k_bne, k_b
    } kind_e;

    logic        clk;
    logic        rst;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    // program words plus the fields they were built from
    logic [31:0] prog   [0:255];
    kind_e       p_kind [0:255];
    logic [4:0]  p_rd   [0:255];
    logic [4:0]  p_rj   [0:255];
    logic [4:0]  p_rk   [0:255];
    logic [31:0] p_imm  [0:255];
    int          n_body;

    logic [31:0] dmem  [0:255];   // DUT side data memory
    logic [31:0] mdmem [0:255];   // model copy
    logic [31:0] mregs [0:31];

    logic [31:0] exp_pc  [0:255];
    logic [31:0] exp_num [0:255];
    logic [31:0] exp_val [0:255];
    int          exp_tag [0:255];
    int          n_exp;
    logic [31:0] st_addr [0:255];
    logic [31:0] st_data [0:255];
    int          n_st;
    int          st_seen;
    int          n_ld;
    int          ld_seen;
    int          n_seen;
    int          cycles;
    int          total_err;

    logic        inst_req;
    logic [31:0] inst_addr_q;
    logic        data_req;
    logic [31:0] data_addr_q;

    string test_name [0:5];
    int    checks    [0:5];
    int    errs      [0:5];

    la_core_top DUT (
        .clk(clk), .rst(rst),
        .inst_sram_en(inst_sram_en), .inst_sram_addr(inst_sram_addr),
        .inst_sram_rdata(inst_sram_rdata),
        .data_sram_en(data_sram_en), .data_sram_we(data_sram_we),
        .data_sram_addr(data_sram_addr), .data_sram_wdata(data_sram_wdata),
        .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] dmem_fill(input int i);
        return i * 32'h9e37_79b1 + 32'h0000_1357;
    endfunction

    function automatic logic [4:0] rand_src();
        return 5'($urandom % 8);   // r0..r7
    endfunction

    function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd,
                                           input logic [4:0] rj, input logic [4:0] rk,
                                           input logic [31:0] imm);
        case (k)
            k_add:   return {la_pkg::op_add_w, rk, rj, rd};
            k_sub:   return {la_pkg::op_sub_w, rk, rj, rd};
            k_slt:   return {la_pkg::op_slt, rk, rj, rd};
            k_sltu:  return {la_pkg::op_sltu, rk, rj, rd};
            k_and:   return {la_pkg::op_and, rk, rj, rd};
            k_or:    return {la_pkg::op_or, rk, rj, rd};
            k_xor:   return {la_pkg::op_xor, rk, rj, rd};
            k_addi:  return {la_pkg::op_addi_w, imm[11:0], rj, rd};
            k_lu12i: return {la_pkg::op_lu12i_w, imm[31:12], rd};
            k_ld:    return {la_pkg::op_ld_w, imm[11:0], rj, rd};
            k_st:    return {la_pkg::op_st_w, imm[11:0], rj, rk};   // data reg in rd field
            k_beq:   return {la_pkg::op_beq, imm[17:2], rj, rk};
            k_bne:   return {la_pkg::op_bne, imm[17:2], rj, rk};
            default: return {la_pkg::op_b, imm[17:2], imm[27:18]};
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - la_pkg::reset_pc;
        if (off < 32'd1024)
            return prog[off[9:2]];
        return 32'h0;   // decodes as a no-op
    endfunction

    task automatic check_value(input int t, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks[t]++;
        if (expected !== actual)
        begin
            errs[t]++;
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name[t], field, expected, actual);
        end
    endtask

    task automatic emit(input kind_e k, input logic [4:0] rd, input logic [4:0] rj,
                        input logic [4:0] rk, input logic [31:0] imm);
        p_kind[n_body] = k;
        p_rd[n_body]   = rd;
        p_rj[n_body]   = rj;
        p_rk[n_body]   = rk;
        p_imm[n_body]  = imm;
        prog[n_body]   = encode(k, rd, rj, rk, imm);
        n_body++;
    endtask

    task automatic gen_program(input int body_len);
        int          r;
        int          span;
        logic [4:0]  rd;
        logic [31:0] imm;
        n_body = 0;
        while (n_body < body_len)
        begin
            r   = $urandom % 100;
            rd  = 5'($urandom % 7 + 1);
            imm = $urandom;
            if (r < 4)
                emit(kind_e'($urandom % 7), 5'd0, rand_src(), rand_src(), 32'h0);  // r0 sink
            else if (r < 45)
                emit(kind_e'($urandom % 7), rd, rand_src(), rand_src(), 32'h0);
            else if (r < 57)
                emit(k_addi, rd, rand_src(), 5'd0, {{20{imm[11]}}, imm[11:0]});
            else if (r < 64)
                emit(k_lu12i, rd, 5'd0, 5'd0, {imm[31:12], 12'h000});
            else if (r < 76)
            begin
                emit(k_ld, rd, 5'd0, 5'd0, {22'd0, imm[7:0], 2'b00});
                if (imm[31] && n_body < body_len)
                    emit(k_add, 5'($urandom % 7 + 1), rd, rand_src(), 32'h0);  // use at once
            end
            else if (r < 88)
            begin
                emit(k_st, 5'd0, 5'd0, rand_src(), {22'd0, imm[7:0], 2'b00});
                if (imm[30] && n_body < body_len)
                    emit(k_ld, rd, 5'd0, 5'd0, {22'd0, imm[7:0], 2'b00});   // read back
            end
            else
            begin
                span = 1 + int'(imm[21:20]);   // forward only, never past the end
                if (n_body + span > body_len)
                    span = body_len - n_body;
                emit(kind_e'(k_beq + r % 3), 5'd0, rand_src(), rand_src(), 32'(span * 4));
            end
        end
        emit(k_b, 5'd0, 5'd0, 5'd0, 32'h0);   // self-loop
    endtask

    // instruction-level model, walks the program up to the self-loop
    task automatic run_model(input int loop_idx);
        int          idx;
        int          steps;
        logic [4:0]  prev_ld;
        bit          taken;
        bit          taken_prev;
        bit          wr;
        bit          reads_ld;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] addr;
        for (int i = 0; i < 32; i++)
            mregs[i] = '0;
        for (int i = 0; i < 256; i++)
            mdmem[i] = dmem_fill(i);
        idx        = 0;
        steps      = 0;
        prev_ld    = '0;
        taken_prev = 1'b0;
        n_exp      = 0;
        n_st       = 0;
        n_ld       = 0;
        while (idx < loop_idx && steps < 1000)
        begin
            a     = mregs[p_rj[idx]];
            b     = mregs[p_rk[idx]];
            addr  = a + p_imm[idx];
            v     = '0;
            taken = 1'b0;
            wr    = !(p_kind[idx] inside {k_st, k_beq, k_bne, k_b});
            case (p_kind[idx])
                k_add:   v = a + b;
                k_sub:   v = a - b;
                k_slt:   v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                k_sltu:  v = (a < b) ? 32'd1 : 32'd0;
                k_and:   v = a & b;
                k_or:    v = a | b;
                k_xor:   v = a ^ b;
                k_addi:  v = addr;
                k_lu12i: v = p_imm[idx];
                k_ld:
                begin
                    v = mdmem[addr[9:2]];
                    n_ld++;
                end
                k_st:
                begin
                    mdmem[addr[9:2]] = b;
                    st_addr[n_st]    = addr;
                    st_data[n_st]    = b;
                    n_st++;
                end
                k_beq:   taken = (a == b);
                k_bne:   taken = (a != b);
                default: taken = 1'b1;
            endcase
            reads_ld = prev_ld != '0 && p_kind[idx] != k_lu12i &&
                       (p_rj[idx] == prev_ld || (p_kind[idx] <= k_xor && p_rk[idx] == prev_ld));
            if (wr && p_rd[idx] != '0)
            begin
                exp_pc[n_exp]  = la_pkg::reset_pc + 32'(idx * 4);
                exp_num[n_exp] = 32'(p_rd[idx]);
                exp_val[n_exp] = v;
                exp_tag[n_exp] = taken_prev ? 3 : reads_ld ? 1 : (p_kind[idx] == k_ld) ? 2 : 0;
                n_exp++;
                mregs[p_rd[idx]] = v;
            end
            prev_ld    = (p_kind[idx] == k_ld) ? p_rd[idx] : 5'd0;
            taken_prev = taken;
            idx        = taken ? idx + int'(p_imm[idx] >> 2) : idx + 1;
            steps++;
        end
    endtask

    task automatic take_store();
        dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        if (st_seen < n_st)
        begin
            check_value(2, "store addr", st_addr[st_seen], data_sram_addr);
            check_value(2, "store data", st_data[st_seen], data_sram_wdata);
            check_value(2, "store strobes", 32'hf, data_sram_we);
        end
        else
        begin
            $display("store_load: unexpected store to address %h", data_sram_addr);
            errs[2]++;
        end
        st_seen++;
    endtask

    task automatic take_record();
        int t;
        if (n_seen >= n_exp)
        begin
            $display("trace_count: extra trace record at pc %h", debug_wb_pc);
            errs[5]++;
        end
        else
        begin
            t = exp_tag[n_seen];
            if (n_seen == 0)
                check_value(4, "first pc", exp_pc[0], debug_wb_pc);
            check_value(t, "pc", exp_pc[n_seen], debug_wb_pc);
            check_value(t, "wnum", exp_num[n_seen], debug_wb_rf_wnum);
            check_value(t, "wdata", exp_val[n_seen], debug_wb_rf_wdata);
        end
        n_seen++;
    endtask

    // SRAMs latch the request at the clock edge, the word follows on the falling edge
    always @(posedge clk)
    begin
        inst_req    <= inst_sram_en;
        inst_addr_q <= inst_sram_addr;
        data_req    <= data_sram_en;
        data_addr_q <= data_sram_addr;
        if (!rst && data_sram_en && data_sram_we != 4'h0)
            take_store();
        if (!rst && data_sram_en && data_sram_we == 4'h0)
            ld_seen++;   // one read per executed load
    end

    always @(negedge clk)
    begin
        if (inst_req)
            inst_sram_rdata = fetch_word(inst_addr_q);
        if (data_req)
            data_sram_rdata = dmem[data_addr_q[9:2]];
    end

    initial
    begin
        rst             = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        n_seen          = 0;
        st_seen         = 0;
        ld_seen         = 0;
        void'($urandom(32'h4d7e));
        test_name[0] = "alu_forwarding";
        test_name[1] = "load_use_stall";
        test_name[2] = "store_load";
        test_name[3] = "branch_squash";
        test_name[4] = "reset_start";
        test_name[5] = "trace_count";
        for (int t = 0; t < 6; t++)
        begin
            checks[t] = 0;
            errs[t]   = 0;
        end
        for (int i = 0; i < 256; i++)
        begin
            prog[i] = 32'h0;
            dmem[i] = dmem_fill(i);
        end
        gen_program(199);
        run_model(199);

        for (int c = 0; c < 5; c++)
        begin
            @(negedge clk);
            check_value(4, "trace we in reset", 32'h0, debug_wb_rf_we);
            check_value(4, "data we in reset", 32'h0, data_sram_we);
        end
        rst = 1'b0;

        cycles = 0;
        while (n_seen < n_exp && cycles < 5000)
        begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_we != 4'h0)
                take_record();
        end
        if (n_seen < n_exp)
        begin
            $display("trace_count: timeout after %0d cycles with %0d of %0d records seen",
                     cycles, n_seen, n_exp);
            errs[5]++;
        end
        // the self-loop must stay silent
        for (int c = 0; c < 20; c++)
        begin
            @(negedge clk);
            if (debug_wb_rf_we != 4'h0)
                take_record();
        end
        check_value(5, "record count", n_exp, n_seen);
        check_value(2, "store count", n_st, st_seen);
        check_value(2, "load count", n_ld, ld_seen);

        total_err = DUT.u_chk.fail_count;
        for (int t = 0; t < 6; t++)
        begin
            $display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errs[t]);
            total_err += errs[t];
        end
        $display("total: %0d records, %0d stores, %0d errors, %0d assertion failures",
                 n_seen, st_seen, total_err, DUT.u_chk.fail_count);
        if (total_err == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- la_core.f
hw/la_pkg.sv
hw/pipe_reg.sv
hw/fetch_stage.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/hazard_unit.sv
hw/mem_wb_stage.sv
hw/la_core_top.sv
bench/la_core_chk.sv
bench/la_core_tb.sv
